// File: common/video_pkg.sv
// ================================================
// Raster sizes, data widths and CPU register map
// shared by every block of the video subsystem
// ================================================
`default_nettype none

package video_pkg;

    // Raster position and pixel types
    typedef logic [6:0]  hpos_t;
    typedef logic [6:0]  vpos_t;
    typedef logic [3:0]  pxl_idx_t;
    typedef logic [14:0] rgb555_t;

    // Graphics memory: world row above column group
    typedef logic [9:0]  gfx_addr_t;
    typedef logic [31:0] gfx_word_t;

    typedef logic [6:0]  scroll_x_t;
    typedef logic [5:0]  scroll_y_t;

    typedef logic [5:0]  cpu_addr_t;
    typedef logic [15:0] cpu_data_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT
    } fetch_state_t;

    // Raster, visible area starts at count 0
    localparam int H_TOTAL   = 80;
    localparam int V_TOTAL   = 40;
    localparam int H_ACTIVE  = 64;
    localparam int V_ACTIVE  = 32;
    localparam int HS_START  = 68;
    localparam int HS_END    = 72;
    localparam int VS_START  = 34;
    localparam int VS_END    = 36;
    localparam int VINT_LINE = 32;

    // Nine groups per line leave room for fine scroll
    localparam int PXL_PER_GROUP   = 8;
    localparam int GROUPS_PER_LINE = 9;
    localparam int LBUF_LEN        = GROUPS_PER_LINE * PXL_PER_GROUP;

    // CPU register map, 0x00..0x0F is the palette
    localparam cpu_addr_t REG_HSCROLL = 6'h10;
    localparam cpu_addr_t REG_VSCROLL = 6'h11;
    localparam cpu_addr_t REG_CTRL    = 6'h12;
    localparam cpu_addr_t REG_VPOS    = 6'h14;

endpackage

`default_nettype wire

// File: common/video_timing_if.sv
// ================================================
// Raster position and blanking, driven by the timer
// ================================================
`default_nettype none

interface video_timing_if import video_pkg::*; ();

    logic  pxl_cen;
    hpos_t hdump;
    vpos_t vdump;
    // Line being prepared by the layer
    vpos_t vrender;
    // High inside the visible area
    logic  lhbl;
    logic  lvbl;

    modport src (
        output pxl_cen, hdump, vdump, vrender, lhbl, lvbl
    );

    modport snk (
        input pxl_cen, hdump, vdump, vrender, lhbl, lvbl
    );

endinterface

`default_nettype wire

// File: common/gfx_fetch_if.sv
// ================================================
// Graphics word requests from the layer to memory
// ================================================
`default_nettype none

interface gfx_fetch_if import video_pkg::*; ();

    // Request channel with valid/ready
    logic      req_valid;
    logic      req_ready;
    gfx_addr_t req_addr;

    // One response pulse per accepted request
    logic      rsp_valid;
    gfx_word_t rsp_data;

    modport master (
        output req_valid, req_addr,
        input  req_ready, rsp_valid, rsp_data
    );

    modport slave (
        input  req_valid, req_addr,
        output req_ready, rsp_valid, rsp_data
    );

endinterface

`default_nettype wire

// File: rtl/video_timer.sv
// ================================================
// Pixel enable, raster counters, sync and vint
// ================================================
`default_nettype none

module video_timer import video_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    video_timing_if.src    tim,
    output logic           hs,
    output logic           vs,
    output logic           vint
);

    logic  cen;
    hpos_t hcnt;
    vpos_t vcnt;
    logic  line_end;
    logic  frame_end;

    assign line_end  = hcnt == hpos_t'(H_TOTAL - 1);
    assign frame_end = vcnt == vpos_t'(V_TOTAL - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cen  <= 1'b0;
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            // Pixel clock is half of clk
            cen <= ~cen;
            if (cen) begin
                if (line_end) begin
                    hcnt <= '0;
                    vcnt <= frame_end ? '0 : vcnt + 1'b1;
                end else begin
                    hcnt <= hcnt + 1'b1;
                end
            end
        end
    end

    assign tim.pxl_cen = cen;
    assign tim.hdump   = hcnt;
    assign tim.vdump   = vcnt;
    assign tim.vrender = frame_end ? '0 : vcnt + 1'b1;
    assign tim.lhbl    = hcnt < hpos_t'(H_ACTIVE);
    assign tim.lvbl    = vcnt < vpos_t'(V_ACTIVE);

    // Sync pulses are active low
    assign hs = !(hcnt >= hpos_t'(HS_START) && hcnt < hpos_t'(HS_END));
    assign vs = !(vcnt >= vpos_t'(VS_START) && vcnt < vpos_t'(VS_END));

    // First pixel of the vint line
    assign vint = vcnt == vpos_t'(VINT_LINE) && hcnt == '0;

    a_hcnt_range: assert property (@(posedge clk) disable iff (!rst_n)
        hcnt < hpos_t'(H_TOTAL) && vcnt < vpos_t'(V_TOTAL));

    a_vint_once: assert property (@(posedge clk) disable iff (!rst_n)
        vint && cen |=> !vint);

endmodule

`default_nettype wire

// File: video_regs/video_regs.sv
// ================================================
// CPU register block: palette access, scroll and
// control shadows copied to the layer on vint
// ================================================
`default_nettype none

module video_regs import video_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    video_timing_if.snk    tim,
    input  logic           vint,
    input  logic           cpu_cs,
    input  logic           cpu_we,
    input  cpu_addr_t      cpu_addr,
    input  cpu_data_t      cpu_wdata,
    output cpu_data_t      cpu_rdata,
    output logic           pal_we,
    output pxl_idx_t       pal_idx,
    output rgb555_t        pal_wdata,
    input  rgb555_t        pal_rdata,
    output scroll_x_t      hscroll,
    output scroll_y_t      vscroll,
    output logic           layer_en
);

    scroll_x_t sh_hscroll;
    scroll_y_t sh_vscroll;
    logic      sh_en;
    logic      pal_sel;
    logic      wr;
    logic      rd;
    logic      frame_copy;

    assign pal_sel = cpu_addr[5:4] == 2'b00;
    assign wr      = cpu_cs && cpu_we;
    assign rd      = cpu_cs && !cpu_we;

    // Palette goes straight to the mixer
    assign pal_we    = wr && pal_sel;
    assign pal_idx   = cpu_addr[3:0];
    assign pal_wdata = cpu_wdata[14:0];

    // Once per frame, on the single enable inside vint
    assign frame_copy = vint && tim.pxl_cen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sh_hscroll <= '0;
            sh_vscroll <= '0;
            sh_en      <= 1'b0;
        end else if (wr) begin
            case (cpu_addr)
                REG_HSCROLL: sh_hscroll <= cpu_wdata[6:0];
                REG_VSCROLL: sh_vscroll <= cpu_wdata[5:0];
                REG_CTRL:    sh_en      <= cpu_wdata[0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hscroll  <= '0;
            vscroll  <= '0;
            layer_en <= 1'b0;
        end else if (frame_copy) begin
            hscroll  <= sh_hscroll;
            vscroll  <= sh_vscroll;
            layer_en <= sh_en;
        end
    end

    // Read data one clock after the access
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cpu_rdata <= '0;
        end else if (rd) begin
            if (pal_sel) begin
                cpu_rdata <= {1'b0, pal_rdata};
            end else begin
                case (cpu_addr)
                    REG_HSCROLL: cpu_rdata <= {9'd0, sh_hscroll};
                    REG_VSCROLL: cpu_rdata <= {10'd0, sh_vscroll};
                    REG_CTRL:    cpu_rdata <= {15'd0, sh_en};
                    REG_VPOS:    cpu_rdata <= {9'd0, tim.vdump};
                    default:     cpu_rdata <= '0;
                endcase
            end
        end
    end

    // Active values only move on the first pixel of the vint line
    a_copy_on_vint: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable({hscroll, vscroll, layer_en}) |->
            $past(vint && tim.pxl_cen && tim.vdump == vpos_t'(VINT_LINE) &&
                  tim.hdump == '0));

endmodule

`default_nettype wire

// File: scroll_layer/scroll_layer.sv
// ================================================
// Scrolling bitmap layer: fetches the next line into
// a ping-pong buffer while the other one is shown
// ================================================
`default_nettype none

module scroll_layer import video_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    video_timing_if.snk    tim,
    input  scroll_x_t      hscroll,
    input  scroll_y_t      vscroll,
    input  logic           layer_en,
    gfx_fetch_if.master    fetch,
    output pxl_idx_t       pxl
);

    fetch_state_t state;
    logic         wr_sel;
    logic         rd_sel;
    logic         start_pend;
    logic [3:0]   grp;
    logic [5:0]   row_q;
    logic [3:0]   col_base;
    logic [2:0]   fine_wr;
    logic [2:0]   fine_rd;
    logic         line_start;
    logic         rsp_take;
    logic         last_grp;
    logic [6:0]   rd_idx;
    logic         rd_hit;

    pxl_idx_t                   line_buf [2][LBUF_LEN];
    logic [GROUPS_PER_LINE-1:0] grp_vld  [2];

    // Buffers swap as hdump wraps to 0
    assign line_start = tim.pxl_cen && tim.hdump == hpos_t'(H_TOTAL - 1);
    assign rd_sel     = ~wr_sel;
    assign last_grp   = grp == 4'(GROUPS_PER_LINE - 1);

    // A response owed to an older line is dropped
    assign rsp_take = state == WAIT && fetch.rsp_valid && !start_pend;

    assign fetch.req_valid = state == REQ;
    assign fetch.req_addr  = {row_q, 4'(col_base + grp)};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            grp        <= '0;
            start_pend <= 1'b0;
            wr_sel     <= 1'b0;
            fine_rd    <= '0;
        end else begin
            if (line_start) begin
                wr_sel     <= ~wr_sel;
                fine_rd    <= fine_wr;
                start_pend <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (start_pend && !line_start) begin
                        start_pend <= 1'b0;
                        grp        <= '0;
                        state      <= REQ;
                    end
                end
                REQ: begin
                    if (fetch.req_ready) begin
                        state <= WAIT;
                    end
                end
                WAIT: begin
                    if (fetch.rsp_valid) begin
                        grp   <= grp + 1'b1;
                        state <= (last_grp || start_pend) ? IDLE : REQ;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Line geometry, latched once per fetch run
    always_ff @(posedge clk) begin
        if (state == IDLE && start_pend && !line_start) begin
            row_q    <= tim.vrender[5:0] + vscroll;
            col_base <= hscroll[6:3];
            fine_wr  <= hscroll[2:0];
        end
    end

    // Groups not yet fetched read as transparent
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grp_vld[0] <= '0;
            grp_vld[1] <= '0;
        end else begin
            if (line_start) begin
                grp_vld[rd_sel] <= '0;
            end
            if (rsp_take) begin
                grp_vld[wr_sel][grp] <= 1'b1;
            end
        end
    end

    // Unpack eight nibbles, lowest pixel first
    always_ff @(posedge clk) begin
        if (rsp_take) begin
            for (int k = 0; k < PXL_PER_GROUP; k++) begin
                line_buf[wr_sel][{grp, 3'(k)}] <= fetch.rsp_data[4*k +: 4];
            end
        end
    end

    assign rd_idx = tim.hdump + {4'd0, fine_rd};
    assign rd_hit = tim.lhbl && tim.lvbl && layer_en && grp_vld[rd_sel][rd_idx[6:3]];

    always_ff @(posedge clk) begin
        if (tim.pxl_cen) begin
            pxl <= rd_hit ? line_buf[rd_sel][rd_idx] : '0;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.req_valid && !fetch.req_ready |=>
            fetch.req_valid && $stable(fetch.req_addr));

    a_rsp_owed: assert property (@(posedge clk) disable iff (!rst_n)
        fetch.rsp_valid |-> state == WAIT);

endmodule

`default_nettype wire

// File: rtl/color_mixer.sv
// ================================================
// Palette lookup and output blanking, one pixel
// stage after the layer
// ================================================
`default_nettype none

module color_mixer import video_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    video_timing_if.snk    tim,
    input  pxl_idx_t       pxl,
    input  logic           pal_we,
    input  pxl_idx_t       pal_idx,
    input  rgb555_t        pal_wdata,
    output rgb555_t        pal_rdata,
    output logic [4:0]     red,
    output logic [4:0]     green,
    output logic [4:0]     blue,
    output logic           lhbl_dly,
    output logic           lvbl_dly
);

    rgb555_t palette [16];
    rgb555_t color;
    logic    lhbl_d1;
    logic    lvbl_d1;
    logic    visible;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            palette[pal_idx] <= pal_wdata;
        end
    end

    // CPU read port
    assign pal_rdata = palette[pal_idx];

    // Index 0 also looks up, entry 0 is the backdrop
    assign color   = palette[pxl];
    assign visible = lhbl_d1 && lvbl_d1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else if (tim.pxl_cen) begin
            // First stage lines up with the layer output
            lhbl_d1  <= tim.lhbl;
            lvbl_d1  <= tim.lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            if (visible) begin
                red   <= color[14:10];
                green <= color[9:5];
                blue  <= color[4:0];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/video_top.sv
// ================================================
// Video subsystem top: timer, registers, layer and
// mixer, with the graphics bus on plain ports
// ================================================
`default_nettype none

module video_top import video_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    // CPU bus
    input  logic       cpu_cs,
    input  logic       cpu_we,
    input  cpu_addr_t  cpu_addr,
    input  cpu_data_t  cpu_wdata,
    output cpu_data_t  cpu_rdata,

    // Graphics memory
    output logic       gfx_req_valid,
    input  logic       gfx_req_ready,
    output gfx_addr_t  gfx_req_addr,
    input  logic       gfx_rsp_valid,
    input  gfx_word_t  gfx_rsp_data,

    // Video out
    output logic       pxl_cen,
    output logic       hs,
    output logic       vs,
    output logic       vint,
    output logic       lhbl_dly,
    output logic       lvbl_dly,
    output logic [4:0] red,
    output logic [4:0] green,
    output logic [4:0] blue
);

    video_timing_if tim();
    gfx_fetch_if    fetch();

    logic      pal_we;
    pxl_idx_t  pal_idx;
    rgb555_t   pal_wdata;
    rgb555_t   pal_rdata;
    scroll_x_t hscroll;
    scroll_y_t vscroll;
    logic      layer_en;
    pxl_idx_t  layer_pxl;

    assign pxl_cen = tim.pxl_cen;

    assign gfx_req_valid   = fetch.req_valid;
    assign gfx_req_addr    = fetch.req_addr;
    assign fetch.req_ready = gfx_req_ready;
    assign fetch.rsp_valid = gfx_rsp_valid;
    assign fetch.rsp_data  = gfx_rsp_data;

    video_timer u_timer (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .tim   ( tim   ),
        .hs    ( hs    ),
        .vs    ( vs    ),
        .vint  ( vint  )
    );

    video_regs u_regs (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .tim       ( tim       ),
        .vint      ( vint      ),
        .cpu_cs    ( cpu_cs    ),
        .cpu_we    ( cpu_we    ),
        .cpu_addr  ( cpu_addr  ),
        .cpu_wdata ( cpu_wdata ),
        .cpu_rdata ( cpu_rdata ),
        .pal_we    ( pal_we    ),
        .pal_idx   ( pal_idx   ),
        .pal_wdata ( pal_wdata ),
        .pal_rdata ( pal_rdata ),
        .hscroll   ( hscroll   ),
        .vscroll   ( vscroll   ),
        .layer_en  ( layer_en  )
    );

    scroll_layer u_layer (
        .clk      ( clk       ),
        .rst_n    ( rst_n     ),
        .tim      ( tim       ),
        .hscroll  ( hscroll   ),
        .vscroll  ( vscroll   ),
        .layer_en ( layer_en  ),
        .fetch    ( fetch     ),
        .pxl      ( layer_pxl )
    );

    color_mixer u_mixer (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .tim       ( tim       ),
        .pxl       ( layer_pxl ),
        .pal_we    ( pal_we    ),
        .pal_idx   ( pal_idx   ),
        .pal_wdata ( pal_wdata ),
        .pal_rdata ( pal_rdata ),
        .red       ( red       ),
        .green     ( green     ),
        .blue      ( blue      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  )
    );

endmodule

`default_nettype wire

// File: dv/gfx_mem_model.sv
// ================================================
// Graphics memory for the testbench: random ready,
// responses 1 to 4 clocks after each request
// ================================================
`default_nettype none

module gfx_mem_model import video_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    output logic      req_ready,
    input  gfx_addr_t req_addr,
    output logic      rsp_valid,
    output gfx_word_t rsp_data
);

    logic      take;
    logic      busy;
    gfx_addr_t addr_s;
    gfx_addr_t pend_addr;
    int        left;
    int        stall;

    // Nibble k of a word is row + column group + k
    function automatic gfx_word_t word_at(input gfx_addr_t a);
        gfx_word_t w;
        for (int k = 0; k < PXL_PER_GROUP; k++) begin
            w[4*k +: 4] = 4'(int'(a[9:4]) + int'(a[3:0]) + k);
        end
        return w;
    endfunction

    initial begin
        void'($urandom(68));
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp_data  = '0;
        busy      = 1'b0;
        pend_addr = '0;
        left      = 0;
        stall     = 0;
        forever begin
            @(posedge clk);
            take   = req_valid && req_ready;
            addr_s = req_addr;
            #1;
            rsp_valid = 1'b0;
            if (!rst_n) begin
                busy      = 1'b0;
                req_ready = 1'b0;
                stall     = 0;
            end else begin
                if (take) begin
                    busy      = 1'b1;
                    left      = 1 + int'($urandom % 4);
                    pend_addr = addr_s;
                end
                if (busy) begin
                    left = left - 1;
                    if (left == 0) begin
                        rsp_valid = 1'b1;
                        rsp_data  = word_at(pend_addr);
                        busy      = 1'b0;
                    end
                end
                // Ready is never low for more than three clocks
                if (stall >= 3 || $urandom % 4 != 0) begin
                    req_ready = 1'b1;
                    stall     = 0;
                end else begin
                    req_ready = 1'b0;
                    stall     = stall + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/video_tb.sv
// ================================================
// Testbench for the video subsystem: scroll table,
// register readback and full-frame pixel checks
// ================================================
`default_nettype none

module video_tb import video_pkg::*; ();

    typedef struct packed {
        scroll_x_t hscroll;
        scroll_y_t vscroll;
        logic      en;
        rgb555_t   seed;
    } row_t;

    localparam int N_ROWS  = 6;
    localparam int TIMEOUT = H_TOTAL * V_TOTAL * 4;

    // Scroll, enable and palette seed per frame
    localparam row_t ROWS [N_ROWS] = '{
        '{7'd0,   6'd0,  1'b1, 15'h0421},
        '{7'd16,  6'd8,  1'b1, 15'h1357},
        '{7'd5,   6'd3,  1'b1, 15'h2b6d},
        '{7'd125, 6'd63, 1'b1, 15'h0e39},
        '{7'd93,  6'd45, 1'b0, 15'h3a1f},
        '{7'd42,  6'd21, 1'b1, 15'h1d83}
    };

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cpu_cs;
    logic       cpu_we;
    cpu_addr_t  cpu_addr;
    cpu_data_t  cpu_wdata;
    cpu_data_t  cpu_rdata;
    logic       gfx_req_valid;
    logic       gfx_req_ready;
    gfx_addr_t  gfx_req_addr;
    logic       gfx_rsp_valid;
    gfx_word_t  gfx_rsp_data;
    logic       pxl_cen;
    logic       hs;
    logic       vs;
    logic       vint;
    logic       lhbl_dly;
    logic       lvbl_dly;
    logic [4:0] red;
    logic [4:0] green;
    logic [4:0] blue;
    rgb555_t    pal [16];

    always #4 clk = ~clk;

    video_top dut0 (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .cpu_cs        ( cpu_cs        ),
        .cpu_we        ( cpu_we        ),
        .cpu_addr      ( cpu_addr      ),
        .cpu_wdata     ( cpu_wdata     ),
        .cpu_rdata     ( cpu_rdata     ),
        .gfx_req_valid ( gfx_req_valid ),
        .gfx_req_ready ( gfx_req_ready ),
        .gfx_req_addr  ( gfx_req_addr  ),
        .gfx_rsp_valid ( gfx_rsp_valid ),
        .gfx_rsp_data  ( gfx_rsp_data  ),
        .pxl_cen       ( pxl_cen       ),
        .hs            ( hs            ),
        .vs            ( vs            ),
        .vint          ( vint          ),
        .lhbl_dly      ( lhbl_dly      ),
        .lvbl_dly      ( lvbl_dly      ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          )
    );

    gfx_mem_model mem0 (
        .clk       ( clk           ),
        .rst_n     ( rst_n         ),
        .req_valid ( gfx_req_valid ),
        .req_ready ( gfx_req_ready ),
        .req_addr  ( gfx_req_addr  ),
        .rsp_valid ( gfx_rsp_valid ),
        .rsp_data  ( gfx_rsp_data  )
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
        end
    endtask

    task automatic cpu_write(input cpu_addr_t a, input cpu_data_t d);
        @(posedge clk);
        #1;
        cpu_cs    = 1'b1;
        cpu_we    = 1'b1;
        cpu_addr  = a;
        cpu_wdata = d;
        @(posedge clk);
        #1;
        cpu_cs = 1'b0;
        cpu_we = 1'b0;
    endtask

    // Read data is registered on the access clock
    task automatic cpu_read(input cpu_addr_t a, output cpu_data_t d);
        @(posedge clk);
        #1;
        cpu_cs   = 1'b1;
        cpu_we   = 1'b0;
        cpu_addr = a;
        @(posedge clk);
        #1;
        cpu_cs = 1'b0;
        d      = cpu_rdata;
    endtask

    task automatic wait_vint();
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            seen = vint && pxl_cen;
        end
        if (!seen) begin
            stop_run("Timeout while waiting for vint");
        end
    endtask

    // One vint per frame of H_TOTAL x V_TOTAL pixels, sync widths
    // counted over that frame
    task automatic check_vint_period();
        int   n;
        int   pix;
        int   hs_low;
        int   vs_low;
        logic seen;
        logic cen_q;
        wait_vint();
        n      = 0;
        pix    = 0;
        hs_low = 0;
        vs_low = 0;
        seen   = 1'b0;
        cen_q  = pxl_cen;
        while (!seen && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            // Pixel enable on every second clock
            check("pxl_cen", 32'(pxl_cen), 32'(!cen_q));
            cen_q = pxl_cen;
            if (pxl_cen) begin
                pix++;
                seen = vint;
                if (!hs) begin
                    hs_low++;
                end
                if (!vs) begin
                    vs_low++;
                end
            end
        end
        if (!seen) begin
            stop_run("Timeout while waiting for the second vint");
        end
        check("vint_period", 32'(pix), 32'(H_TOTAL * V_TOTAL));
        check("hs_low_pixels", 32'(hs_low), 32'((HS_END - HS_START) * V_TOTAL));
        check("vs_low_pixels", 32'(vs_low), 32'((VS_END - VS_START) * H_TOTAL));
    endtask

    task automatic load_row(input row_t r);
        cpu_data_t d;
        for (int i = 0; i < 16; i++) begin
            pal[i] = rgb555_t'(int'(r.seed) * (i + 1));
            cpu_write(cpu_addr_t'(i), {1'b0, pal[i]});
        end
        cpu_write(REG_HSCROLL, {9'd0, r.hscroll});
        cpu_write(REG_VSCROLL, {10'd0, r.vscroll});
        cpu_write(REG_CTRL, {15'd0, r.en});
        for (int i = 0; i < 16; i++) begin
            cpu_read(cpu_addr_t'(i), d);
            check($sformatf("pal_rdata[%0d]", i), 32'(d), 32'({1'b0, pal[i]}));
        end
        cpu_read(REG_HSCROLL, d);
        check("hscroll_rdata", 32'(d), 32'(r.hscroll));
        cpu_read(REG_VSCROLL, d);
        check("vscroll_rdata", 32'(d), 32'(r.vscroll));
        cpu_read(REG_CTRL, d);
        check("ctrl_rdata", 32'(d), 32'(r.en));
        // Read shortly after vint, so still in vertical blanking
        cpu_read(REG_VPOS, d);
        check("vpos_in_vblank", 32'(d >= 16'(V_ACTIVE) && d < 16'(V_TOTAL)), 32'd1);
    endtask

    // Pixels are sampled on the falling edge of their last clock
    task automatic capture_frame(input row_t r);
        int      n;
        int      x;
        int      y;
        int      cnt;
        int      idx;
        int      sx;
        int      sy;
        rgb555_t exp_c;
        sx = int'(r.hscroll);
        sy = int'(r.vscroll);
        n  = 0;
        @(negedge clk);
        while (lvbl_dly && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (lvbl_dly) begin
            stop_run("Timeout while waiting for vertical blanking");
        end
        x   = 0;
        y   = 0;
        cnt = 0;
        n   = 0;
        while (cnt < H_ACTIVE * V_ACTIVE && n < TIMEOUT) begin
            @(negedge clk);
            n++;
            if (pxl_cen && lhbl_dly && lvbl_dly) begin
                idx   = (((y + sy) % 64) + ((x + sx) % 128) / 8 + (x + sx) % 8) % 16;
                exp_c = r.en ? pal[idx] : pal[0];
                check($sformatf("red[%0d,%0d]", x, y), 32'(red), 32'(exp_c[14:10]));
                check($sformatf("green[%0d,%0d]", x, y), 32'(green), 32'(exp_c[9:5]));
                check($sformatf("blue[%0d,%0d]", x, y), 32'(blue), 32'(exp_c[4:0]));
                x++;
                if (x == H_ACTIVE) begin
                    x = 0;
                    y++;
                end
                cnt++;
            end else if (pxl_cen) begin
                check("rgb_blank", 32'({red, green, blue}), 32'd0);
            end
        end
        if (cnt < H_ACTIVE * V_ACTIVE) begin
            stop_run("Timeout while capturing the visible frame");
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        cpu_cs    = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check("hs", 32'(hs), 32'd1);
        check("vs", 32'(vs), 32'd1);
        check("vint", 32'(vint), 32'd0);
        check("lhbl_dly", 32'(lhbl_dly), 32'd0);
        check("lvbl_dly", 32'(lvbl_dly), 32'd0);
        check("rgb", 32'({red, green, blue}), 32'd0);
        check("cpu_rdata", 32'(cpu_rdata), 32'd0);
        check("gfx_req_valid", 32'(gfx_req_valid), 32'd0);
        check_vint_period();

        // Writes land in vblank, the frame after the next vint is checked
        for (int i = 0; i < N_ROWS; i++) begin
            wait_vint();
            load_row(ROWS[i]);
            wait_vint();
            capture_frame(ROWS[i]);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
common/video_pkg.sv
common/video_timing_if.sv
common/gfx_fetch_if.sv
rtl/video_timer.sv
video_regs/video_regs.sv
scroll_layer/scroll_layer.sv
rtl/color_mixer.sv
rtl/video_top.sv
dv/gfx_mem_model.sv
dv/video_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the video subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module video_tb -Mdir obj_dir -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vvideo_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

exit 0
